/* src/unaligned_mem_access_pkg.sv */
package unaligned_mem_access_pkg;

    // data word and write mask width
    parameter int DATA_BITS = 32;

    // byte address width
    parameter int ADDR_BITS = 32;

    // bytes per data word
    parameter int BYTE_LANES = 4;

    // byte offset inside a word
    parameter int OFFSET_BITS = 2;

    // defaults handed down from the top level
    parameter int DEFAULT_DEPTH_WORDS  = 64;
    parameter int DEFAULT_READ_LATENCY = 2;

    // one byte address seen either flat or as word index plus byte offset
    typedef union packed {
        logic [ADDR_BITS-1:0] flat;
        struct packed {
            // aligned word index
            logic [ADDR_BITS-OFFSET_BITS-1:0] word;
            // byte lane of the first byte
            logic [OFFSET_BITS-1:0]           offset;
        } split;
    } mem_addr_t;

endpackage

/* src/word_ram.sv */
`timescale 1ns/1ps

module word_ram #(
    parameter int DEPTH_WORDS  = unaligned_mem_access_pkg::DEFAULT_DEPTH_WORDS,
    parameter int READ_LATENCY = unaligned_mem_access_pkg::DEFAULT_READ_LATENCY
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          mem_start,
    input  logic                                          mem_write,
    input  logic [unaligned_mem_access_pkg::ADDR_BITS
                  - unaligned_mem_access_pkg::OFFSET_BITS - 1:0] mem_word,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0] mem_wdata,
    output logic                                          mem_ready,
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0] mem_rdata,
    output logic                                          mem_rdata_valid
);
    import unaligned_mem_access_pkg::*;

    // index width for the word array, at least one bit
    localparam int IDX_BITS = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    // countdown must hold READ_LATENCY itself
    localparam int CNT_BITS = $clog2(READ_LATENCY + 1);

    logic [DATA_BITS-1:0] mem [DEPTH_WORDS];
    logic [CNT_BITS-1:0]  lat_cnt;
    logic [IDX_BITS-1:0]  idx;
    logic                 accept;

    // the sequencer already wraps the index into range
    assign idx    = mem_word[IDX_BITS-1:0];
    assign accept = mem_start && mem_ready;

    // busy while a read is in flight, writes never stall
    assign mem_ready = (lat_cnt == '0);

    // valid on the last count, READ_LATENCY cycles after the accept edge
    assign mem_rdata_valid = (lat_cnt == CNT_BITS'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lat_cnt <= '0;
        end else if (accept && !mem_write) begin
            lat_cnt <= CNT_BITS'(READ_LATENCY);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    // write lands on the accept edge
    // read word is sampled then and held until its valid pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            if (mem_write) begin
                mem[idx] <= mem_wdata;
            end else begin
                mem_rdata <= mem[idx];
            end
        end
    end

endmodule

/* src/access_sequencer.sv */
`timescale 1ns/1ps

module access_sequencer #(
    parameter int DEPTH_WORDS = unaligned_mem_access_pkg::DEFAULT_DEPTH_WORDS
) (
    input  logic                                          clk,
    input  logic                                          rst_n,

    // request side
    input  logic                                          cmd_start,
    input  logic                                          cmd_write,
    input  unaligned_mem_access_pkg::mem_addr_t           addr,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0] wdata,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0] wmask,
    output logic                                          cmd_ready,
    output logic                                          rdata_valid,

    // word memory side
    output logic                                          mem_start,
    output logic                                          mem_write,
    output logic [unaligned_mem_access_pkg::ADDR_BITS
                  - unaligned_mem_access_pkg::OFFSET_BITS - 1:0] mem_word,
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0] mem_wdata,
    input  logic                                          mem_ready,
    input  logic                                          mem_rdata_valid,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0] mem_rdata,

    // lane merge side
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0] saved_lo,
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0] saved_hi,
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0] saved_wdata,
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0] saved_wmask,
    output logic [unaligned_mem_access_pkg::OFFSET_BITS-1:0] offset,
    output logic                                          hi_sel,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0] merged_word
);
    import unaligned_mem_access_pkg::*;

    localparam int WORD_BITS = ADDR_BITS - OFFSET_BITS;

    // memory depth at word index width, for the wrap
    localparam logic [WORD_BITS-1:0] DEPTH_W = WORD_BITS'(DEPTH_WORDS);

    // state encodings
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_RD_LO = 3'd1;
    localparam logic [2:0] ST_RD_HI = 3'd2;
    localparam logic [2:0] ST_WR_LO = 3'd3;
    localparam logic [2:0] ST_WR_HI = 3'd4;
    localparam logic [2:0] ST_DONE  = 3'd5;

    logic [2:0]           state;
    logic                 saved_write;
    mem_addr_t            saved_addr;
    logic [WORD_BITS-1:0] word_lo;
    logic [WORD_BITS-1:0] word_hi;
    logic                 two_words;
    logic                 accept;

    // any non-zero offset spans two words
    assign two_words = (saved_addr.split.offset != '0);

    // byte addresses wrap modulo the memory, so the word index does too
    assign word_lo = saved_addr.split.word % DEPTH_W;
    assign word_hi = (word_lo == DEPTH_W - 1'b1) ? '0 : word_lo + 1'b1;

    assign offset = saved_addr.split.offset;
    assign hi_sel = (state == ST_WR_HI);

    assign cmd_ready   = (state == ST_IDLE);
    assign rdata_valid = (state == ST_DONE);

    // every command state issues once mem_ready is high
    // in a read state ready stays low until the valid pulse, so no reissue
    always_comb begin
        case (state)
            ST_RD_LO, ST_RD_HI, ST_WR_LO, ST_WR_HI: mem_start = mem_ready;
            default:                                mem_start = 1'b0;
        endcase
    end

    assign mem_write = (state == ST_WR_LO) || (state == ST_WR_HI);
    assign mem_word  = ((state == ST_RD_HI) || (state == ST_WR_HI)) ? word_hi : word_lo;

    // merge result serves every write
    // with a full mask at offset zero it is the raw data
    assign mem_wdata = merged_word;

    assign accept = mem_start && mem_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            saved_write <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_start) begin
                        saved_write <= cmd_write;
                        // skip the read phase only for aligned full-mask writes
                        if (cmd_write && (addr.split.offset == '0) && (wmask == '1)) begin
                            state <= ST_WR_LO;
                        end else begin
                            state <= ST_RD_LO;
                        end
                    end
                end
                ST_RD_LO: begin
                    if (mem_rdata_valid) begin
                        if (two_words) begin
                            state <= ST_RD_HI;
                        end else if (saved_write) begin
                            state <= ST_WR_LO;
                        end else begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_RD_HI: begin
                    if (mem_rdata_valid) begin
                        state <= saved_write ? ST_WR_LO : ST_DONE;
                    end
                end
                ST_WR_LO: begin
                    if (accept) begin
                        state <= two_words ? ST_WR_HI : ST_IDLE;
                    end
                end
                ST_WR_HI: begin
                    if (accept) begin
                        state <= ST_IDLE;
                    end
                end
                ST_DONE: begin
                    // result was presented for one cycle
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request payload, taken only while idle
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && cmd_start) begin
            saved_addr  <= addr;
            saved_wdata <= wdata;
            saved_wmask <= wmask;
        end
    end

    // read words are registered on their valid edge
    always_ff @(posedge clk) begin
        if (mem_rdata_valid && (state == ST_RD_LO)) begin
            saved_lo <= mem_rdata;
        end
        if (mem_rdata_valid && (state == ST_RD_HI)) begin
            saved_hi <= mem_rdata;
        end
    end

endmodule

/* src/lane_merge.sv */
`timescale 1ns/1ps

module lane_merge (
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0]   saved_lo,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0]   saved_hi,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0]   saved_wdata,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0]   saved_wmask,
    input  logic [unaligned_mem_access_pkg::OFFSET_BITS-1:0] offset,
    input  logic                                            hi_sel,
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0]   merged_word,
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0]   read_word
);
    import unaligned_mem_access_pkg::*;

    localparam int BYTE_BITS = DATA_BITS / BYTE_LANES;

    // bitwise select between old and new under the mask
    function automatic logic [BYTE_BITS-1:0] merge_byte(
        input logic [BYTE_BITS-1:0] old_b,
        input logic [BYTE_BITS-1:0] new_b,
        input logic [BYTE_BITS-1:0] mask_b
    );
        return (old_b & ~mask_b) | (new_b & mask_b);
    endfunction

    // write merge
    // low word: lanes below the offset untouched, data byte 0 lands at the offset
    // high word: the data bytes that spilled over land from lane 0 upward
    always_comb begin
        int off;
        int src;
        off = int'(offset);
        src = 0;
        for (int j = 0; j < BYTE_LANES; j++) begin
            if (!hi_sel) begin
                if (j < off) begin
                    merged_word[BYTE_BITS*j +: BYTE_BITS] = saved_lo[BYTE_BITS*j +: BYTE_BITS];
                end else begin
                    src = j - off;
                    merged_word[BYTE_BITS*j +: BYTE_BITS] = merge_byte(
                        saved_lo[BYTE_BITS*j +: BYTE_BITS],
                        saved_wdata[BYTE_BITS*src +: BYTE_BITS],
                        saved_wmask[BYTE_BITS*src +: BYTE_BITS]);
                end
            end else begin
                if (j < off) begin
                    // top data bytes, counted from lane BYTE_LANES - off
                    src = j + BYTE_LANES - off;
                    merged_word[BYTE_BITS*j +: BYTE_BITS] = merge_byte(
                        saved_hi[BYTE_BITS*j +: BYTE_BITS],
                        saved_wdata[BYTE_BITS*src +: BYTE_BITS],
                        saved_wmask[BYTE_BITS*src +: BYTE_BITS]);
                end else begin
                    merged_word[BYTE_BITS*j +: BYTE_BITS] = saved_hi[BYTE_BITS*j +: BYTE_BITS];
                end
            end
        end
    end

    // read extraction, little endian
    // result byte k comes from lane offset+k of the low word, or spills into the high word
    always_comb begin
        int off;
        int src;
        off = int'(offset);
        src = 0;
        for (int k = 0; k < BYTE_LANES; k++) begin
            src = off + k;
            if (src < BYTE_LANES) begin
                read_word[BYTE_BITS*k +: BYTE_BITS] = saved_lo[BYTE_BITS*src +: BYTE_BITS];
            end else begin
                read_word[BYTE_BITS*k +: BYTE_BITS] =
                    saved_hi[BYTE_BITS*(src - BYTE_LANES) +: BYTE_BITS];
            end
        end
    end

endmodule

/* src/unaligned_mem_access.sv */
`timescale 1ns/1ps

module unaligned_mem_access #(
    parameter int DEPTH_WORDS  = unaligned_mem_access_pkg::DEFAULT_DEPTH_WORDS,
    parameter int READ_LATENCY = unaligned_mem_access_pkg::DEFAULT_READ_LATENCY
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          cmd_start,
    input  logic                                          cmd_write,
    input  logic [unaligned_mem_access_pkg::ADDR_BITS-1:0] addr,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0] wdata,
    input  logic [unaligned_mem_access_pkg::DATA_BITS-1:0] wmask,
    output logic                                          cmd_ready,
    output logic [unaligned_mem_access_pkg::DATA_BITS-1:0] rdata,
    output logic                                          rdata_valid
);
    import unaligned_mem_access_pkg::*;

    // sequencer to word memory
    logic                             mem_start;
    logic                             mem_write;
    logic [ADDR_BITS-OFFSET_BITS-1:0] mem_word;
    logic [DATA_BITS-1:0]             mem_wdata;
    logic                             mem_ready;
    logic [DATA_BITS-1:0]             mem_rdata;
    logic                             mem_rdata_valid;

    // sequencer to lane merge
    logic [DATA_BITS-1:0]             saved_lo;
    logic [DATA_BITS-1:0]             saved_hi;
    logic [DATA_BITS-1:0]             saved_wdata;
    logic [DATA_BITS-1:0]             saved_wmask;
    logic [OFFSET_BITS-1:0]           offset;
    logic                             hi_sel;
    logic [DATA_BITS-1:0]             merged_word;

    access_sequencer #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) seq_inst (
        .clk, .rst_n,
        .cmd_start, .cmd_write, .addr, .wdata, .wmask,
        .cmd_ready, .rdata_valid,
        .mem_start, .mem_write, .mem_word, .mem_wdata,
        .mem_ready, .mem_rdata_valid, .mem_rdata,
        .saved_lo, .saved_hi, .saved_wdata, .saved_wmask,
        .offset, .hi_sel, .merged_word
    );

    word_ram #(
        .DEPTH_WORDS  (DEPTH_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) ram_inst (
        .clk, .rst_n,
        .mem_start, .mem_write, .mem_word, .mem_wdata,
        .mem_ready, .mem_rdata, .mem_rdata_valid
    );

    // read result comes straight from the registered words, valid only with rdata_valid
    lane_merge merge_inst (
        .saved_lo, .saved_hi, .saved_wdata, .saved_wmask,
        .offset, .hi_sel,
        .merged_word,
        .read_word (rdata)
    );

endmodule

/* bench/access_sequencer_assertions.sv */
`timescale 1ns/1ps

module access_sequencer_assertions (
    input logic clk,
    input logic rst_n,
    input logic cmd_ready,
    input logic rdata_valid,
    input logic mem_start,
    input logic mem_ready,
    input logic saved_write
);

    // no command toward the word memory while it is busy
    mem_start_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        mem_start |-> mem_ready)
        else $error("mem_start raised while mem_ready is low");

    // result cycle is never an idle cycle
    ready_valid_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd_ready && rdata_valid))
        else $error("cmd_ready and rdata_valid high together");

    // only reads present a result
    valid_only_for_reads: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> !saved_write)
        else $error("rdata_valid raised for a write request");

    // idle right after reset
    ready_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> cmd_ready)
        else $error("cmd_ready low after reset release");

endmodule

/* bench/unaligned_mem_access_tb.sv */
`timescale 1ns/1ps

module unaligned_mem_access_tb;
    import unaligned_mem_access_pkg::*;

    localparam int DEPTH_WORDS    = DEFAULT_DEPTH_WORDS;
    localparam int MEM_BYTES      = DEPTH_WORDS * BYTE_LANES;
    localparam int TIMEOUT_CYCLES = 50;

    logic                 clk;
    logic                 rst_n;
    logic                 cmd_start;
    logic                 cmd_write;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
    logic [DATA_BITS-1:0] wmask;
    logic                 cmd_ready;
    logic [DATA_BITS-1:0] rdata;
    logic                 rdata_valid;

    // byte image of the memory, little endian
    logic [7:0] model_mem [MEM_BYTES];
    int         errors = 0;

    unaligned_mem_access unaligned_mem_access_inst (
        .clk, .rst_n,
        .cmd_start, .cmd_write, .addr, .wdata, .wmask,
        .cmd_ready, .rdata, .rdata_valid
    );

    // saved_write is internal to the sequencer
    bind access_sequencer access_sequencer_assertions seq_checks (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_ready   (cmd_ready),
        .rdata_valid (rdata_valid),
        .mem_start   (mem_start),
        .mem_ready   (mem_ready),
        .saved_write (saved_write)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // byte k lands at addr + k, wrapped to the memory size
    task automatic model_write(input logic [31:0] a, input logic [31:0] d,
                               input logic [31:0] m);
        logic [31:0] byte_addr;
        int          idx;
        for (int k = 0; k < BYTE_LANES; k++) begin
            byte_addr = a + 32'(k);
            idx = int'(byte_addr % 32'(MEM_BYTES));
            model_mem[idx] = (model_mem[idx] & ~m[8*k +: 8]) | (d[8*k +: 8] & m[8*k +: 8]);
        end
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] a);
        logic [31:0] byte_addr;
        logic [31:0] result;
        result = '0;
        for (int k = 0; k < BYTE_LANES; k++) begin
            byte_addr = a + 32'(k);
            result[8*k +: 8] = model_mem[int'(byte_addr % 32'(MEM_BYTES))];
        end
        return result;
    endfunction

    // sampled at the falling edge where the outputs are settled
    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!cmd_ready) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: cmd_ready stayed low for %0d cycles %s", cycles, what);
                $display("SIMULATION FAILED");
                $fatal(1, "wait for cmd_ready expired");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_rdata_valid(input logic [31:0] a);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rdata_valid) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: no rdata_valid within %0d cycles for the read at 0x%08h",
                         cycles, a);
                $display("SIMULATION FAILED");
                $fatal(1, "wait for rdata_valid expired");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // start is held for one edge, accepted since cmd_ready was high
    // with noise a second start is raised while the DUT is busy
    task automatic issue_request(input logic wr, input logic [31:0] a, input logic [31:0] d,
                                 input logic [31:0] m, input bit noise);
        wait_ready("before a new request");
        @(posedge clk);
        cmd_start <= 1'b1;
        cmd_write <= wr;
        addr      <= a;
        wdata     <= d;
        wmask     <= m;
        @(posedge clk);
        if (noise) begin
            // state has left idle, so this start must be dropped
            cmd_write <= ($urandom % 2) == 1;
            addr      <= $urandom;
            wdata     <= $urandom;
            wmask     <= $urandom;
            @(posedge clk);
        end
        cmd_start <= 1'b0;
    endtask

    task automatic write_bytes(input logic [31:0] a, input logic [31:0] d,
                               input logic [31:0] m, input bit noise);
        issue_request(1'b1, a, d, m, noise);
        model_write(a, d, m);
        wait_ready("after a write");
    endtask

    task automatic read_and_check(input logic [31:0] a, input bit noise);
        logic [31:0] expected;
        expected = model_read(a);
        issue_request(1'b0, a, $urandom, $urandom, noise);
        wait_rdata_valid(a);
        compare_value($sformatf("rdata at 0x%08h", a), rdata, expected);
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] m;
        logic        wr;
        bit          noise;
        void'($urandom(19224));
        rst_n     <= 1'b0;
        cmd_start <= 1'b0;
        cmd_write <= 1'b0;
        addr      <= '0;
        wdata     <= '0;
        wmask     <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // idle levels, then fill every word through the plain write path
        @(negedge clk);
        compare_value("cmd_ready", 32'(cmd_ready), 32'h1);
        compare_value("rdata_valid", 32'(rdata_valid), 32'h0);
        for (int w = 0; w < DEPTH_WORDS; w++) begin
            write_bytes(32'(w * 4), $urandom, '1, 1'b0);
        end

        // aligned full words
        for (int i = 0; i < 20; i++) begin
            a = ($urandom % 32'(DEPTH_WORDS)) << 2;
            write_bytes(a, $urandom, '1, 1'b0);
            read_and_check(a, 1'b0);
        end

        // aligned read-modify-write under a random mask
        for (int i = 0; i < 20; i++) begin
            a = ($urandom % 32'(DEPTH_WORDS)) << 2;
            write_bytes(a, $urandom, $urandom, 1'b0);
            read_and_check(a, 1'b0);
        end

        // unaligned writes, the last word spills over into word 0
        for (int off = 1; off < BYTE_LANES; off++) begin
            for (int pick = 0; pick < 2; pick++) begin
                word = (pick == 0) ? ($urandom % 32'(DEPTH_WORDS)) : 32'(DEPTH_WORDS - 1);
                a = (word << 2) | 32'(off);
                m = (pick == 0) ? 32'hffff_ffff : $urandom;
                write_bytes(a, $urandom, m, 1'b0);
                read_and_check(a, 1'b0);
                read_and_check(a - 32'd1, 1'b0);
                read_and_check(a + 32'd1, 1'b0);
                read_and_check(a + 32'd3, 1'b0);
            end
        end

        // every offset of random addresses, upper bits included
        for (int i = 0; i < 10; i++) begin
            word = $urandom;
            for (int off = 0; off < BYTE_LANES; off++) begin
                read_and_check({word[31:2], 2'(off)}, 1'b0);
            end
        end

        // mixed traffic with stray starts while busy
        for (int i = 0; i < 300; i++) begin
            wr    = ($urandom % 2) == 1;
            a     = $urandom;
            noise = ($urandom % 3) == 0;
            if (($urandom % 4) == 0) begin
                a[1:0] = 2'b00;
            end
            m = (($urandom % 4) == 0) ? 32'hffff_ffff : $urandom;
            if (wr) begin
                write_bytes(a, $urandom, m, noise);
            end else begin
                read_and_check(a, noise);
            end
        end

        // whole memory once more, catches a stray start that wrote somewhere
        for (int w = 0; w < DEPTH_WORDS; w++) begin
            read_and_check(32'(w * 4), 1'b0);
        end

        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* unaligned_mem_access.f */
src/unaligned_mem_access_pkg.sv
src/word_ram.sv
src/access_sequencer.sv
src/lane_merge.sv
src/unaligned_mem_access.sv
bench/access_sequencer_assertions.sv
bench/unaligned_mem_access_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := unaligned_mem_access_tb
FILELIST  := unaligned_mem_access.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
